//--- Bender.yml
package:
  name: mdc

sources:
  - logic/mdc_pkg.sv
  - logic/hamming_decoder.sv
  - logic/matrix_intake.sv
  - logic/minor_stage.sv
  - logic/laplace_stage.sv
  - logic/result_stage.sv
  - logic/mdc_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/mdc_tb.sv

//--- dv/mdc_tb.sv
/*
 * testbench for the matrix determinant engine: table driven stimulus,
 * hamming encoding with bit flips, reference model and output monitor
 */
`timescale 1ns/1ps
`default_nettype none

module mdc_tb
    import mdc_pkg::*;
;

    localparam int K_RAND  = 0;   // $random elements
    localparam int K_RAMP  = 1;
    localparam int K_EXT_A = 2;   // only -1024 and 1023
    localparam int K_EXT_B = 3;
    localparam int N_ENT   = 13;

    typedef struct packed {
        logic [MODE_W-1:0] mode;
        int                kind;
        int                flip;    // codeword bit position, 0 = clean
        int                gap;     // idle cycles after the matrix
        int                pause;   // in_valid low before element 8
    } entry_t;

    // ========================================================================
    // stimulus table
    // ========================================================================
    entry_t stim [N_ENT] = '{
        //  mode      kind     flip gap pause
        '{5'b00100, K_RAMP,    0,   2,  0},
        '{5'b00100, K_RAND,    0,   3,  0},
        '{5'b10110, K_RAMP,    0,   2,  0},
        '{5'b10110, K_RAND,    0,   1,  0},
        '{5'b10110, K_EXT_A,   0,   2,  0},
        '{5'b10110, K_EXT_B,   5,   2,  0},
        '{5'b00100, K_RAND,   13,   2,  0},
        '{5'b00110, K_RAND,    0,   1,  0},   // old 3x3 code
        '{5'b11111, K_RAND,    3,   1,  0},
        '{5'b10110, K_RAND,    0,   0,  0},   // back to back from here
        '{5'b00100, K_RAND,    0,   0,  0},
        '{5'b10110, K_RAND,    9,   2,  5},
        '{5'b00100, K_RAMP,    0,   3,  3}
    };

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic [CODE_W-1:0]      in_data;
    logic [MODE_CODE_W-1:0] in_mode;
    logic             out_valid;
    logic [OUT_W-1:0] out_data;

    integer seed = 32'hda62_9f4a;
    int     cyc = 0;
    int     limit;
    elem_t  cur [NUM_ELEMS];     // matrix being driven

    int     exp_kind [$];        // 0 zero bus, 1 windows, 2 determinant
    int     exp_cyc  [$];
    minor_t exp_win  [$];
    det_t   exp_det  [$];

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    mdc_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // ========================================================================
    // encoder and reference model
    // ========================================================================
    function automatic logic [15:0] hamming_encode(input logic [10:0] d, input int dw,
                                                   input int n);
        logic [15:0] cw;
        int          k;
        int          s;
        cw = '0;
        k  = dw - 1;
        s  = 0;
        for (int pos = 1; pos <= n; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                cw[n - pos] = d[k];
                k = k - 1;
            end
        end
        for (int pos = 1; pos <= n; pos++) begin
            if (cw[n - pos]) s = s ^ pos;
        end
        // each parity bit cancels its own syndrome bit
        for (int b = 0; (1 << b) <= n; b++) begin
            if (s[b]) cw[n - (1 << b)] = 1'b1;
        end
        return cw;
    endfunction

    function automatic elem_t make_elem(input int kind, input int i);
        logic [15:0] ext_a;
        logic [15:0] ext_b;
        ext_a = 16'hb5a3;
        ext_b = 16'h4e71;
        case (kind)
            K_RAMP:  return elem_t'((i * 137) % 401 - 200);
            K_EXT_A: return ext_a[i] ? elem_t'(-1024) : elem_t'(1023);
            K_EXT_B: return ext_b[i] ? elem_t'(-1024) : elem_t'(1023);
            default: return elem_t'($random(seed));
        endcase
    endfunction

    function automatic longint x(input int r, input int c);
        return longint'(cur[r * MAT_N + c]);
    endfunction

    // 3x3 minor of rows 1..3 without column skip
    function automatic longint minor3(input int skip);
        int c [3];
        int n;
        n = 0;
        for (int j = 0; j < MAT_N; j++) begin
            if (j != skip) begin
                c[n] = j;
                n = n + 1;
            end
        end
        return x(1, c[0]) * (x(2, c[1]) * x(3, c[2]) - x(2, c[2]) * x(3, c[1]))
             - x(1, c[1]) * (x(2, c[0]) * x(3, c[2]) - x(2, c[2]) * x(3, c[0]))
             + x(1, c[2]) * (x(2, c[0]) * x(3, c[1]) - x(2, c[1]) * x(3, c[0]));
    endfunction

    task automatic push_expected(input logic [MODE_W-1:0] mode, input int due);
        longint d;
        exp_cyc.push_back(due);
        if (mode == MODE_CODE_2X2) begin
            exp_kind.push_back(1);
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    exp_win.push_back(minor_t'(x(r, c) * x(r + 1, c + 1)
                                             - x(r, c + 1) * x(r + 1, c)));
                end
            end
        end else if (mode == MODE_CODE_4X4) begin
            d = 0;
            for (int j = 0; j < MAT_N; j++) begin
                d = (j % 2 == 0) ? d + x(0, j) * minor3(j) : d - x(0, j) * minor3(j);
            end
            exp_kind.push_back(2);
            exp_det.push_back(det_t'(d));
        end else begin
            exp_kind.push_back(0);
        end
    endtask

    // ========================================================================
    // compare tasks
    // ========================================================================
    task automatic check_window(input int w, input minor_t exp,
                                input logic [FIELD_W-1:0] got);
        if (got !== {exp[MINOR_W-1], exp})
            report_error($sformatf("window %0d expected %0d, got %0d",
                                   w, exp, $signed(got)));
    endtask

    task automatic check_det(input det_t exp, input logic [OUT_W-1:0] got);
        if (got !== {{(OUT_W - DET_W){exp[DET_W-1]}}, exp})
            report_error($sformatf("determinant expected %0d, got %h", exp, got));
    endtask

    task automatic check_zero(input string what, input logic [OUT_W-1:0] got);
        if (got !== '0)
            report_error($sformatf("%s expected all zero, got %h", what, got));
    endtask

    // ========================================================================
    // driver
    // ========================================================================
    task automatic run_entry(input int e);
        logic [15:0]            cw;
        logic [MODE_CODE_W-1:0] mc;
        int                     fp;
        for (int i = 0; i < NUM_ELEMS; i++) cur[i] = make_elem(stim[e].kind, i);
        mc = MODE_CODE_W'(hamming_encode({6'b0, stim[e].mode}, MODE_W, MODE_CODE_W));
        if (stim[e].flip != 0) begin
            fp = (stim[e].flip - 1) % MODE_CODE_W + 1;
            mc[MODE_CODE_W - fp] = ~mc[MODE_CODE_W - fp];
        end
        for (int i = 0; i < NUM_ELEMS; i++) begin
            if (i == 8 && stim[e].pause > 0) begin
                in_valid = 1'b0;
                repeat (stim[e].pause) @(negedge clk);
            end
            cw = hamming_encode(cur[i], ELEM_W, CODE_W);
            if (stim[e].flip != 0) begin
                fp = (stim[e].flip - 1 + i) % CODE_W + 1;   // walks over the bits
                cw[CODE_W - fp] = ~cw[CODE_W - fp];
            end
            in_valid = 1'b1;
            in_data  = cw[CODE_W-1:0];
            in_mode  = (i == 0) ? mc : ~mc;   // ignored after element 0
            if (i == NUM_ELEMS - 1) push_expected(stim[e].mode, cyc + 4);
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_data  = '0;
        repeat (stim[e].gap) @(negedge clk);
    endtask

    // ========================================================================
    // monitor and watchdog
    // ========================================================================
    always @(negedge clk) begin
        int kind;
        int due;
        if (rst_n) begin
            if (out_valid && exp_kind.size() == 0) begin
                report_error("out_valid pulse with no matrix pending");
            end else if (out_valid) begin
                due  = exp_cyc.pop_front();
                kind = exp_kind.pop_front();
                if (cyc != due)
                    report_error($sformatf("out_valid at cycle %0d, expected %0d", cyc, due));
                case (kind)
                    1: begin
                        for (int w = 0; w < NUM_WINDOWS; w++)
                            check_window(w, exp_win.pop_front(),
                                         out_data[(NUM_WINDOWS - 1 - w) * FIELD_W +: FIELD_W]);
                    end
                    2:       check_det(exp_det.pop_front(), out_data);
                    default: check_zero("unknown mode result", out_data);
                endcase
            end else begin
                check_zero("idle bus", out_data);
            end
        end
    end

    always @(negedge clk) begin
        if (cyc >= limit) begin
            $display("timeout: the run did not complete within %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int longest;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        longest  = 0;
        for (int e = 0; e < N_ENT; e++) begin
            if (stim[e].gap + stim[e].pause > longest) longest = stim[e].gap + stim[e].pause;
        end
        limit = N_ENT * (NUM_ELEMS + 3 + longest) + 50;
        @(posedge rst_n);
        @(negedge clk);
        for (int e = 0; e < N_ENT; e++) run_entry(e);
        while (exp_kind.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);   // bus must stay quiet
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
/*
 * testbench clock and reset, 8 ns period with reset held for 4 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // released away from the sampling edge
    end

endmodule

`default_nettype wire

//--- flist.f
logic/mdc_pkg.sv
logic/hamming_decoder.sv
logic/matrix_intake.sv
logic/minor_stage.sv
logic/laplace_stage.sv
logic/result_stage.sv
logic/mdc_top.sv
dv/tb_clock_gen.sv
dv/mdc_tb.sv

//--- logic/hamming_decoder.sv
/*
 * hamming decoder, single error correcting, for any data width
 * position 1 is the codeword msb, parity bits at powers of two
 */
`timescale 1ns/1ps
`default_nettype none

module hamming_decoder #(
    parameter  int DATA_W = 11,
    // smallest p with 2**p >= DATA_W + p + 1
    localparam int PAR_W  = $clog2(DATA_W + $clog2(DATA_W) + 1),
    localparam int CODE_N = DATA_W + PAR_W
) (
    input  logic [CODE_N-1:0] code,
    output logic [DATA_W-1:0] data
);

    logic [PAR_W-1:0]  syndrome;
    logic [CODE_N-1:0] fixed;   // codeword after correction

    // xor of the positions of all set bits
    always_comb begin
        syndrome = '0;
        for (int pos = 1; pos <= CODE_N; pos++) begin
            if (code[CODE_N - pos]) begin
                syndrome ^= PAR_W'(pos);
            end
        end
    end

    // flip the flagged bit, syndromes past the end are ignored
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= CODE_N) begin
            fixed[CODE_N - int'(syndrome)] = ~code[CODE_N - int'(syndrome)];
        end
    end

    // data bits are the non power of two positions, msb first
    always_comb begin
        int k;
        k    = DATA_W - 1;
        data = '0;
        for (int pos = 1; pos <= CODE_N; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                data[k] = fixed[CODE_N - pos];
                k       = k - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/laplace_stage.sv
/*
 * pipeline stage 2: products of complementary top and bottom minors,
 * window minors passed on untouched
 */
`timescale 1ns/1ps
`default_nettype none

module laplace_stage
    import mdc_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       minors_valid,
    input  minor_t [2*NUM_PAIRS-1:0]   minors,
    input  mode_e                      mode,
    output logic                       prods_valid,
    output prod_t  [NUM_PAIRS-1:0]     prods,
    output minor_t [NUM_WINDOWS-1:0]   windows,
    output mode_e                      mode_q
);

    prod_t [NUM_PAIRS-1:0] prods_d;

    // top pair k pairs with bottom pair NUM_PAIRS-1-k (01 with 23 etc)
    always_comb begin
        prods_d = '0;
        if (mode == MODE_4X4) begin
            for (int k = 0; k < NUM_PAIRS; k++) begin
                prods_d[k] = prod_t'(minors[k])
                           * prod_t'(minors[2*NUM_PAIRS - 1 - k]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prods_valid <= 1'b0;
        end else begin
            prods_valid <= minors_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (minors_valid) begin
            prods   <= prods_d;
            windows <= minors[NUM_WINDOWS-1:0];   // windows sit in the low entries
            mode_q  <= mode;
        end
    end

    a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        prods_valid == $past(minors_valid));

endmodule

`default_nettype wire

//--- logic/matrix_intake.sv
/*
 * input side: corrects each codeword, fills the 16 element slots in
 * arrival order and latches the mode with element 0
 */
`timescale 1ns/1ps
`default_nettype none

module matrix_intake
    import mdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [CODE_W-1:0]      in_data,
    input  logic [MODE_CODE_W-1:0] in_mode,
    output logic                   full,
    output matrix_t                matrix,
    output mode_e                  mode
);

    logic [ELEM_W-1:0]            elem_dec;
    logic [MODE_W-1:0]            mode_dec;
    logic [$clog2(NUM_ELEMS)-1:0] idx;        // slot of the next element
    mode_e                        mode_map;

    // ========================================================================
    // codeword correction
    // ========================================================================
    hamming_decoder #(.DATA_W(ELEM_W)) u_elem_dec (
        .code (in_data),
        .data (elem_dec)
    );

    hamming_decoder #(.DATA_W(MODE_W)) u_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    always_comb begin
        case (mode_dec)
            MODE_CODE_2X2: mode_map = MODE_2X2;
            MODE_CODE_4X4: mode_map = MODE_4X4;
            default:       mode_map = MODE_NONE;   // 3x3 code lands here too
        endcase
    end

    // ========================================================================
    // element count and strobe
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx  <= '0;
            full <= 1'b0;
        end else begin
            full <= in_valid && (idx == NUM_ELEMS - 1);
            if (in_valid) begin
                idx <= idx + 1'b1;   // wraps to 0 after the last slot
            end
        end
    end

    // payload, held while in_valid is low
    always_ff @(posedge clk) begin
        if (in_valid) begin
            matrix[idx] <= elem_t'(elem_dec);
            if (idx == '0) begin
                mode <= mode_map;
            end
        end
    end

    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(idx) && idx <= NUM_ELEMS - 1);

    // 16 elements minimum between strobes
    a_full_single: assert property (@(posedge clk) disable iff (!rst_n)
        full |=> !full);

endmodule

`default_nettype wire

//--- logic/mdc_pkg.sv
/*
 * matrix determinant engine: shared widths, element and result types,
 * mode enumeration and the decoded mode codes
 */
`default_nettype none

package mdc_pkg;

    // ========================================================================
    // widths and counts
    // ========================================================================
    localparam int ELEM_W      = 11;   // decoded element
    localparam int CODE_W      = 15;   // hamming(15,11) element codeword
    localparam int MODE_W      = 5;    // decoded mode
    localparam int MODE_CODE_W = 9;    // hamming(9,5) mode codeword

    localparam int MAT_N       = 4;
    localparam int NUM_ELEMS   = MAT_N * MAT_N;
    localparam int NUM_WINDOWS = (MAT_N - 1) * (MAT_N - 1);
    localparam int NUM_PAIRS   = 6;    // column pairs of one row pair

    localparam int MINOR_W     = 2 * ELEM_W;
    localparam int PROD_W      = 2 * MINOR_W;
    localparam int DET_W       = PROD_W + 2;   // headroom for six products
    localparam int FIELD_W     = MINOR_W + 1;
    localparam int OUT_W       = NUM_WINDOWS * FIELD_W;

    // ========================================================================
    // mode codes, after hamming correction
    // ========================================================================
    localparam logic [MODE_W-1:0] MODE_CODE_2X2 = 5'b00100;
    localparam logic [MODE_W-1:0] MODE_CODE_4X4 = 5'b10110;

    // ========================================================================
    // types
    // ========================================================================
    typedef logic signed [ELEM_W-1:0]  elem_t;
    typedef logic signed [MINOR_W-1:0] minor_t;
    typedef logic signed [PROD_W-1:0]  prod_t;
    typedef logic signed [DET_W-1:0]   det_t;

    // row-major, element 0 is row 0 col 0
    typedef elem_t [NUM_ELEMS-1:0] matrix_t;

    typedef enum logic [1:0] {
        MODE_NONE,   // any unrecognised code, result forced to zero
        MODE_2X2,
        MODE_4X4
    } mode_e;

endpackage

`default_nettype wire

//--- logic/mdc_top.sv
/*
 * matrix determinant engine top: intake followed by the three stage
 * minor, laplace and result pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module mdc_top
    import mdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [CODE_W-1:0]      in_data,
    input  logic [MODE_CODE_W-1:0] in_mode,
    output logic                   out_valid,
    output logic [OUT_W-1:0]       out_data
);

    // ========================================================================
    // stage to stage wiring
    // ========================================================================
    logic                     full;
    matrix_t                  matrix;
    mode_e                    intake_mode;

    logic                     minors_valid;
    minor_t [2*NUM_PAIRS-1:0] minors;
    mode_e                    minor_mode;

    logic                     prods_valid;
    prod_t  [NUM_PAIRS-1:0]   prods;
    minor_t [NUM_WINDOWS-1:0] windows;
    mode_e                    laplace_mode;

    matrix_intake u_intake (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_mode  (in_mode),
        .full     (full),
        .matrix   (matrix),
        .mode     (intake_mode)
    );

    minor_stage u_minor (
        .clk          (clk),
        .rst_n        (rst_n),
        .full         (full),
        .matrix       (matrix),
        .mode         (intake_mode),
        .minors_valid (minors_valid),
        .minors       (minors),
        .mode_q       (minor_mode)
    );

    laplace_stage u_laplace (
        .clk          (clk),
        .rst_n        (rst_n),
        .minors_valid (minors_valid),
        .minors       (minors),
        .mode         (minor_mode),
        .prods_valid  (prods_valid),
        .prods        (prods),
        .windows      (windows),
        .mode_q       (laplace_mode)
    );

    result_stage u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .prods_valid (prods_valid),
        .prods       (prods),
        .windows     (windows),
        .mode        (laplace_mode),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

//--- logic/minor_stage.sv
/*
 * pipeline stage 1: 2x2 minors, either the nine adjacent windows or
 * the top and bottom row pair minors for the laplace expansion
 */
`timescale 1ns/1ps
`default_nettype none

module minor_stage
    import mdc_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         full,
    input  matrix_t                      matrix,
    input  mode_e                        mode,
    output logic                         minors_valid,
    output minor_t [2*NUM_PAIRS-1:0]     minors,
    output mode_e                        mode_q
);

    // column pairs 01 02 03 12 13 23
    localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
    localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

    minor_t [2*NUM_PAIRS-1:0] minors_d;

    function automatic minor_t det2(elem_t a, elem_t b, elem_t c, elem_t d);
        return minor_t'(a) * minor_t'(d) - minor_t'(b) * minor_t'(c);
    endfunction

    function automatic elem_t el(matrix_t m, int r, int c);
        return m[r * MAT_N + c];
    endfunction

    always_comb begin
        minors_d = '0;
        case (mode)
            MODE_2X2: begin
                // window (r,c) has its top left corner at (r,c)
                for (int r = 0; r < MAT_N - 1; r++) begin
                    for (int c = 0; c < MAT_N - 1; c++) begin
                        minors_d[r * (MAT_N - 1) + c] =
                            det2(el(matrix, r, c),     el(matrix, r, c + 1),
                                 el(matrix, r + 1, c), el(matrix, r + 1, c + 1));
                    end
                end
            end
            MODE_4X4: begin
                for (int k = 0; k < NUM_PAIRS; k++) begin
                    minors_d[k] =   // rows 0 and 1
                        det2(el(matrix, 0, PAIR_A[k]), el(matrix, 0, PAIR_B[k]),
                             el(matrix, 1, PAIR_A[k]), el(matrix, 1, PAIR_B[k]));
                    minors_d[NUM_PAIRS + k] =   // rows 2 and 3
                        det2(el(matrix, 2, PAIR_A[k]), el(matrix, 2, PAIR_B[k]),
                             el(matrix, 3, PAIR_A[k]), el(matrix, 3, PAIR_B[k]));
                end
            end
            default: minors_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minors_valid <= 1'b0;
        end else begin
            minors_valid <= full;
        end
    end

    always_ff @(posedge clk) begin
        if (full) begin
            minors <= minors_d;
            mode_q <= mode;
        end
    end

endmodule

`default_nettype wire

//--- logic/result_stage.sv
/*
 * pipeline stage 3: signed sum of the laplace products and packing of
 * the result bus by mode, registered with out_valid
 */
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import mdc_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       prods_valid,
    input  prod_t  [NUM_PAIRS-1:0]     prods,
    input  minor_t [NUM_WINDOWS-1:0]   windows,
    input  mode_e                      mode,
    output logic                       out_valid,
    output logic   [OUT_W-1:0]         out_data
);

    // laplace signs + - + + - +, set bit means subtract
    localparam logic [NUM_PAIRS-1:0] NEG_MASK = 6'b010010;

    det_t             det;
    logic [OUT_W-1:0] packed_d;

    always_comb begin
        det = '0;
        for (int k = 0; k < NUM_PAIRS; k++) begin
            if (NEG_MASK[k]) det = det - det_t'(prods[k]);
            else             det = det + det_t'(prods[k]);
        end
    end

    always_comb begin
        packed_d = '0;
        case (mode)
            MODE_2X2: begin
                // window 0 in the top field
                for (int w = 0; w < NUM_WINDOWS; w++) begin
                    packed_d[(NUM_WINDOWS - 1 - w) * FIELD_W +: FIELD_W] =
                        FIELD_W'(windows[w]);
                end
            end
            MODE_4X4: packed_d = OUT_W'(det);   // sign extended
            default:  packed_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= prods_valid;
            out_data  <= prods_valid ? packed_d : '0;
        end
    end

    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0);

endmodule

`default_nettype wire
